// ==== source/ConvPkg.sv ====
package ConvPkg;

    // Frame geometry in pixels.
    localparam int ImgWidth  = 10;
    localparam int ImgHeight = 6;

    // Pixels are unsigned, weights are signed two's complement.
    localparam int PixelWidth  = 8;
    localparam int WeightWidth = 8;

    // A 3x3 kernel.
    localparam int KernelTaps   = 9;
    localparam int TapAddrWidth = $clog2(KernelTaps);

    // A pixel gains one zero sign bit before it is multiplied by a signed weight.
    localparam int ProdWidth = PixelWidth + 1 + WeightWidth;

    // Summing nine products needs four more bits of headroom.
    localparam int SumWidth = ProdWidth + 4;

    // Each line buffer plus the three window columns spans one full row.
    localparam int LineDepth = ImgWidth - 3;

    localparam int ColWidth = $clog2(ImgWidth);
    localparam int RowWidth = $clog2(ImgHeight);

    // Register stages from WindowValid to ResultValid.
    localparam int MacLatency = 3;

endpackage

// ==== source/LineBuffer.sv ====
`timescale 1ns/1ps

module LineBuffer import ConvPkg::*; #(
    parameter int Depth = LineDepth
) (
    input  logic                  Clk,
    input  logic                  Rst,
    input  logic                  Shift,
    input  logic [PixelWidth-1:0] DataIn,
    output logic [PixelWidth-1:0] DataOut
);

    // DataOut is the last stage of the delay, so the array holds one pixel fewer.
    logic [PixelWidth-1:0] taps [Depth-1];

    always_ff @(posedge Clk) begin
        if (Shift) begin
            taps[0] <= DataIn;
            for (int i = 1; i < Depth - 1; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    always_ff @(posedge Clk or negedge Rst) begin
        if (!Rst) begin
            DataOut <= '0;
        end else if (Shift) begin
            DataOut <= taps[Depth-2];
        end
    end

endmodule

// ==== source/WindowGen.sv ====
`timescale 1ns/1ps

module WindowGen import ConvPkg::*; (
    input  logic                  Clk,
    input  logic                  Rst,
    input  logic                  PixelValid,
    input  logic [PixelWidth-1:0] Pixel,
    output logic                  WindowValid,
    output logic [PixelWidth-1:0] Win0,
    output logic [PixelWidth-1:0] Win1,
    output logic [PixelWidth-1:0] Win2,
    output logic [PixelWidth-1:0] Win3,
    output logic [PixelWidth-1:0] Win4,
    output logic [PixelWidth-1:0] Win5,
    output logic [PixelWidth-1:0] Win6,
    output logic [PixelWidth-1:0] Win7,
    output logic [PixelWidth-1:0] Win8
);

    // Index 0 of each row holds the rightmost, most recent pixel of that row.
    logic [PixelWidth-1:0] botRow [3];
    logic [PixelWidth-1:0] midRow [3];
    logic [PixelWidth-1:0] topRow [3];
    logic [PixelWidth-1:0] lineOut0;
    logic [PixelWidth-1:0] lineOut1;
    logic [ColWidth-1:0]   col;
    logic [RowWidth-1:0]   row;
    logic                  lastCol;
    logic                  lastRow;
    logic                  interior;

    LineBuffer #(.Depth(LineDepth)) lineBuf0 (
        .Clk    (Clk),
        .Rst    (Rst),
        .Shift  (PixelValid),
        .DataIn (botRow[2]),
        .DataOut(lineOut0)
    );

    LineBuffer #(.Depth(LineDepth)) lineBuf1 (
        .Clk    (Clk),
        .Rst    (Rst),
        .Shift  (PixelValid),
        .DataIn (midRow[2]),
        .DataOut(lineOut1)
    );

    // New pixels enter the bottom row and reach the top row one image row later each step.
    always_ff @(posedge Clk) begin
        if (PixelValid) begin
            botRow[0] <= Pixel;
            botRow[1] <= botRow[0];
            botRow[2] <= botRow[1];
            midRow[0] <= lineOut0;
            midRow[1] <= midRow[0];
            midRow[2] <= midRow[1];
            topRow[0] <= lineOut1;
            topRow[1] <= topRow[0];
            topRow[2] <= topRow[1];
        end
    end

    assign lastCol = (col == ColWidth'(ImgWidth - 1));
    assign lastRow = (row == RowWidth'(ImgHeight - 1));

    // A window is complete once two earlier rows and two earlier columns exist.
    assign interior = (col >= ColWidth'(2)) && (row >= RowWidth'(2));

    always_ff @(posedge Clk or negedge Rst) begin
        if (!Rst) begin
            col         <= '0;
            row         <= '0;
            WindowValid <= 1'b0;
        end else begin
            WindowValid <= PixelValid && interior;
            if (PixelValid) begin
                if (lastCol) begin
                    col <= '0;
                    row <= lastRow ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    assign Win0 = topRow[2];
    assign Win1 = topRow[1];
    assign Win2 = topRow[0];
    assign Win3 = midRow[2];
    assign Win4 = midRow[1];
    assign Win5 = midRow[0];
    assign Win6 = botRow[2];
    assign Win7 = botRow[1];
    assign Win8 = botRow[0];

endmodule

// ==== source/KernelRegs.sv ====
`timescale 1ns/1ps

module KernelRegs import ConvPkg::*; (
    input  logic                           Clk,
    input  logic                           Rst,
    input  logic                           WeightWe,
    input  logic        [TapAddrWidth-1:0] WeightAddr,
    input  logic signed [WeightWidth-1:0]  WeightData,
    output logic signed [WeightWidth-1:0]  Weight0,
    output logic signed [WeightWidth-1:0]  Weight1,
    output logic signed [WeightWidth-1:0]  Weight2,
    output logic signed [WeightWidth-1:0]  Weight3,
    output logic signed [WeightWidth-1:0]  Weight4,
    output logic signed [WeightWidth-1:0]  Weight5,
    output logic signed [WeightWidth-1:0]  Weight6,
    output logic signed [WeightWidth-1:0]  Weight7,
    output logic signed [WeightWidth-1:0]  Weight8
);

    logic signed [WeightWidth-1:0] weights [KernelTaps];

    // Addresses past the last tap are dropped.
    always_ff @(posedge Clk or negedge Rst) begin
        if (!Rst) begin
            for (int i = 0; i < KernelTaps; i++) begin
                weights[i] <= '0;
            end
        end else if (WeightWe && (WeightAddr < TapAddrWidth'(KernelTaps))) begin
            weights[WeightAddr] <= WeightData;
        end
    end

    assign Weight0 = weights[0];
    assign Weight1 = weights[1];
    assign Weight2 = weights[2];
    assign Weight3 = weights[3];
    assign Weight4 = weights[4];
    assign Weight5 = weights[5];
    assign Weight6 = weights[6];
    assign Weight7 = weights[7];
    assign Weight8 = weights[8];

endmodule

// ==== source/MacTree.sv ====
`timescale 1ns/1ps

module MacTree import ConvPkg::*; (
    input  logic                          Clk,
    input  logic                          Rst,
    input  logic                          WindowValid,
    input  logic        [PixelWidth-1:0]  Win0,
    input  logic        [PixelWidth-1:0]  Win1,
    input  logic        [PixelWidth-1:0]  Win2,
    input  logic        [PixelWidth-1:0]  Win3,
    input  logic        [PixelWidth-1:0]  Win4,
    input  logic        [PixelWidth-1:0]  Win5,
    input  logic        [PixelWidth-1:0]  Win6,
    input  logic        [PixelWidth-1:0]  Win7,
    input  logic        [PixelWidth-1:0]  Win8,
    input  logic signed [WeightWidth-1:0] Weight0,
    input  logic signed [WeightWidth-1:0] Weight1,
    input  logic signed [WeightWidth-1:0] Weight2,
    input  logic signed [WeightWidth-1:0] Weight3,
    input  logic signed [WeightWidth-1:0] Weight4,
    input  logic signed [WeightWidth-1:0] Weight5,
    input  logic signed [WeightWidth-1:0] Weight6,
    input  logic signed [WeightWidth-1:0] Weight7,
    input  logic signed [WeightWidth-1:0] Weight8,
    output logic                          ResultValid,
    output logic        [PixelWidth-1:0]  Result
);

    logic        [PixelWidth-1:0]  win    [KernelTaps];
    logic signed [WeightWidth-1:0] weight [KernelTaps];
    logic signed [ProdWidth-1:0]   prod   [KernelTaps];
    logic signed [SumWidth-1:0]    partial [3];
    logic signed [SumWidth-1:0]    total;
    logic        [MacLatency-1:0]  validPipe;

    assign win[0] = Win0;
    assign win[1] = Win1;
    assign win[2] = Win2;
    assign win[3] = Win3;
    assign win[4] = Win4;
    assign win[5] = Win5;
    assign win[6] = Win6;
    assign win[7] = Win7;
    assign win[8] = Win8;

    assign weight[0] = Weight0;
    assign weight[1] = Weight1;
    assign weight[2] = Weight2;
    assign weight[3] = Weight3;
    assign weight[4] = Weight4;
    assign weight[5] = Weight5;
    assign weight[6] = Weight6;
    assign weight[7] = Weight7;
    assign weight[8] = Weight8;

    // Stage 1. The pixel gets a zero sign bit so the product stays signed.
    always_ff @(posedge Clk) begin
        for (int i = 0; i < KernelTaps; i++) begin
            prod[i] <= ProdWidth'($signed({1'b0, win[i]})) * ProdWidth'(weight[i]);
        end
    end

    // Stage 2 sums one window row per partial.
    always_ff @(posedge Clk) begin
        for (int g = 0; g < 3; g++) begin
            partial[g] <= SumWidth'(prod[3*g]) + SumWidth'(prod[3*g+1])
                        + SumWidth'(prod[3*g+2]);
        end
    end

    assign total = partial[0] + partial[1] + partial[2];

    // Stage 3 saturates to the pixel range. A negative total gives 0 and an overflow gives all ones.
    always_ff @(posedge Clk) begin
        if (total[SumWidth-1]) begin
            Result <= '0;
        end else if (|total[SumWidth-2:PixelWidth]) begin
            Result <= '1;
        end else begin
            Result <= total[PixelWidth-1:0];
        end
    end

    always_ff @(posedge Clk or negedge Rst) begin
        if (!Rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[MacLatency-2:0], WindowValid};
        end
    end

    assign ResultValid = validPipe[MacLatency-1];

endmodule

// ==== source/ConvEngine.sv ====
`timescale 1ns/1ps

module ConvEngine import ConvPkg::*; (
    input  logic                           Clk,
    input  logic                           Rst,
    input  logic                           PixelValid,
    input  logic        [PixelWidth-1:0]   Pixel,
    input  logic                           WeightWe,
    input  logic        [TapAddrWidth-1:0] WeightAddr,
    input  logic signed [WeightWidth-1:0]  WeightData,
    output logic                           ResultValid,
    output logic        [PixelWidth-1:0]   Result
);

    logic                          windowValid;
    logic        [PixelWidth-1:0]  win0, win1, win2, win3, win4, win5, win6, win7, win8;
    logic signed [WeightWidth-1:0] weight0, weight1, weight2, weight3, weight4;
    logic signed [WeightWidth-1:0] weight5, weight6, weight7, weight8;

    WindowGen windowGen_i (
        .Clk        (Clk),
        .Rst        (Rst),
        .PixelValid (PixelValid),
        .Pixel      (Pixel),
        .WindowValid(windowValid),
        .Win0(win0), .Win1(win1), .Win2(win2),
        .Win3(win3), .Win4(win4), .Win5(win5),
        .Win6(win6), .Win7(win7), .Win8(win8)
    );

    // Weights are read live by the MAC, so they must be stable while pixels are in flight.
    KernelRegs kernelRegs_i (
        .Clk       (Clk),
        .Rst       (Rst),
        .WeightWe  (WeightWe),
        .WeightAddr(WeightAddr),
        .WeightData(WeightData),
        .Weight0(weight0), .Weight1(weight1), .Weight2(weight2),
        .Weight3(weight3), .Weight4(weight4), .Weight5(weight5),
        .Weight6(weight6), .Weight7(weight7), .Weight8(weight8)
    );

    MacTree macTree_i (
        .Clk        (Clk),
        .Rst        (Rst),
        .WindowValid(windowValid),
        .Win0(win0), .Win1(win1), .Win2(win2),
        .Win3(win3), .Win4(win4), .Win5(win5),
        .Win6(win6), .Win7(win7), .Win8(win8),
        .Weight0(weight0), .Weight1(weight1), .Weight2(weight2),
        .Weight3(weight3), .Weight4(weight4), .Weight5(weight5),
        .Weight6(weight6), .Weight7(weight7), .Weight8(weight8),
        .ResultValid(ResultValid),
        .Result     (Result)
    );

endmodule

// ==== tb/ConvEngineTb.sv ====
`timescale 1ns/1ps

module ConvEngineTb import ConvPkg::*; ();

    localparam int FramePixels  = ImgWidth * ImgHeight;
    localparam int FrameResults = (ImgWidth - 2) * (ImgHeight - 2);
    localparam int NumFrames    = 2;
    localparam int MaxGap       = 3;
    localparam int ResultEdges  = 4;
    localparam int DrainCycles  = 20;

    logic                          Clk;
    logic                          Rst;
    logic                          PixelValid;
    logic        [PixelWidth-1:0]  Pixel;
    logic                          WeightWe;
    logic        [TapAddrWidth-1:0] WeightAddr;
    logic signed [WeightWidth-1:0] WeightData;
    logic                          ResultValid;
    logic        [PixelWidth-1:0]  Result;

    int pixMem [NumFrames][FramePixels];
    int expMem [NumFrames][FrameResults];
    int pixCount [NumFrames];
    int expCount [NumFrames];
    int wFrame[$];
    int wAddr[$];
    int wValue[$];
    int expQ[$];
    int acceptQ[$];
    int cycle = 0;
    int errors = 0;
    int checked = 0;
    int frameResults = 0;
    int totalResults = 0;
    int timeoutLimit = 50;
    int seed = 61;

    ConvEngine dut_i (
        .Clk        (Clk),
        .Rst        (Rst),
        .PixelValid (PixelValid),
        .Pixel      (Pixel),
        .WeightWe   (WeightWe),
        .WeightAddr (WeightAddr),
        .WeightData (WeightData),
        .ResultValid(ResultValid),
        .Result     (Result)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycle <= cycle + 1;
    end

    task automatic checkValue(input string name, input int expected, input int actual);
        checked++;
        if (expected !== actual) begin
            $display("FAIL %s expected 0x%h got 0x%h at cycle %0d", name, expected, actual, cycle);
            errors++;
        end
    endtask

    task automatic readGolden(input int fd);
        logic [7:0]       tag;
        logic [8*160-1:0] rest;
        int               code;
        int               addr;
        int               value;
        int               frame;
        bit               done;
        frame = 0;
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "W") begin
                code = $fscanf(fd, "%d %d", addr, value);
                wFrame.push_back(frame);
                wAddr.push_back(addr);
                wValue.push_back(value);
            end else if (tag == "F") begin
                frame++;
            end else if (frame < 1 || frame > NumFrames) begin
                $display("Golden file holds pixel or result data outside a frame");
                errors++;
                done = 1'b1;
            end else if (tag == "P") begin
                for (int k = 0; k < ImgWidth; k++) begin
                    code = $fscanf(fd, "%d", value);
                    if (pixCount[frame-1] < FramePixels) begin
                        pixMem[frame-1][pixCount[frame-1]] = value;
                    end
                    pixCount[frame-1]++;
                end
            end else if (tag == "E") begin
                for (int k = 0; k < ImgWidth - 2; k++) begin
                    code = $fscanf(fd, "%d", value);
                    if (expCount[frame-1] < FrameResults) begin
                        expMem[frame-1][expCount[frame-1]] = value;
                    end
                    expCount[frame-1]++;
                end
            end else begin
                $display("Golden file has an unknown line tag %c", tag);
                errors++;
                done = 1'b1;
            end
        end
        for (int f = 0; f < NumFrames; f++) begin
            if (pixCount[f] != FramePixels || expCount[f] != FrameResults) begin
                $display("Golden frame %0d holds %0d pixels and %0d results, which is incomplete",
                         f + 1, pixCount[f], expCount[f]);
                errors++;
            end
        end
    endtask

    task automatic loadWeights(input int frame);
        for (int i = 0; i < wAddr.size(); i++) begin
            if (wFrame[i] == frame) begin
                @(posedge Clk);
                #1;
                WeightWe = 1'b1;
                WeightAddr = TapAddrWidth'(wAddr[i]);
                WeightData = WeightWidth'(wValue[i]);
            end
        end
        @(posedge Clk);
        #1;
        WeightWe = 1'b0;
    endtask

    task automatic streamFrame(input int frame, input bit gapped);
        int gap;
        int n;
        frameResults = 0;
        for (int k = 0; k < FrameResults; k++) begin
            expQ.push_back(expMem[frame][k]);
        end
        for (int k = 0; k < FramePixels; k++) begin
            gap = gapped ? ($random(seed) & MaxGap) : 0;
            repeat (gap) begin
                @(posedge Clk);
                #1;
                PixelValid = 1'b0;
            end
            @(posedge Clk);
            #1;
            PixelValid = 1'b1;
            Pixel = PixelWidth'(pixMem[frame][k]);
            // The pixel is taken at the next edge and completes a window when interior.
            if ((k % ImgWidth) >= 2 && (k / ImgWidth) >= 2) begin
                acceptQ.push_back(cycle + 1);
            end
        end
        @(posedge Clk);
        #1;
        PixelValid = 1'b0;
        n = 0;
        while (expQ.size() != 0 && n < DrainCycles) begin
            @(posedge Clk);
            n++;
        end
        repeat (MacLatency + 2) @(posedge Clk);
        if (expQ.size() != 0) begin
            $display("Frame %0d ended with %0d results missing", frame + 1, expQ.size());
            errors++;
            expQ.delete();
        end
        acceptQ.delete();
        checkValue("ResultCount", FrameResults, frameResults);
    endtask

    // Outputs are sampled at the falling edge. A result registered at edge
    // cycle is taken by the consumer at the following rising edge.
    initial begin
        forever begin
            @(negedge Clk);
            if (Rst && ResultValid) begin
                totalResults++;
                frameResults++;
                if (expQ.size() == 0) begin
                    $display("Result 0x%h arrived at cycle %0d with no result expected",
                             Result, cycle);
                    errors++;
                end else begin
                    checkValue("Result", expQ.pop_front(), int'(Result));
                end
                if (acceptQ.size() != 0) begin
                    checkValue("ResultLatency", ResultEdges, cycle + 1 - acceptQ.pop_front());
                end
            end
        end
    end

    initial begin
        @(posedge Clk);
        while (cycle < timeoutLimit) begin
            @(posedge Clk);
        end
        $display("Timeout after %0d cycles before all frames completed", cycle);
        $display("Results checked %0d, errors %0d", checked, errors + 1);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int fd;
        Rst = 1'b0;
        PixelValid = 1'b0;
        Pixel = '0;
        WeightWe = 1'b0;
        WeightAddr = '0;
        WeightData = '0;
        fd = $fopen("tb/conv_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file tb/conv_golden.txt");
            errors++;
        end else begin
            readGolden(fd);
            $fclose(fd);
            timeoutLimit = 2 * (2 * pixCount[0] + pixCount[1]) + MaxGap * pixCount[0] + 50;
            if (errors == 0) begin
                repeat (3) @(posedge Clk);
                #1;
                Rst = 1'b1;
                repeat (10) @(posedge Clk);
                checkValue("ResultValid", 0, totalResults);
                loadWeights(0);
                streamFrame(0, 1'b0);
                streamFrame(0, 1'b1);
                loadWeights(1);
                streamFrame(1, 1'b0);
            end
        end
        $display("Results checked %0d, errors %0d", checked, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/conv_golden.txt ====
# W addr weight | F starts a frame | P one row of 10 pixels | E one row of 8 results
# Decimal values. W lines before an F line hold the weights for that frame.
W 0 -1
W 1 -1
W 2 -1
W 3 -1
W 4 8
W 5 -1
W 6 -1
W 7 -1
W 8 -1
F
P 50 50 50 50 50 50 50 50 50 50
P 50 50 90 50 50 50 50 50 50 50
P 50 50 50 50 50 10 50 50 50 50
P 50 50 50 50 50 50 50 50 200 50
P 50 50 50 60 45 50 50 50 50 50
P 50 50 50 50 50 50 50 50 50 50
E 0 255 0 40 40 40 0 0
E 0 0 0 40 0 40 0 0
E 0 0 0 35 45 40 0 255
E 0 0 85 0 5 0 0 0
W 0 -1
W 1 0
W 2 0
W 3 0
W 4 2
W 5 0
W 6 0
W 7 0
W 8 1
F
P 0 5 10 15 20 25 30 35 40 45
P 10 15 20 25 30 35 40 45 50 55
P 20 25 30 35 40 45 50 55 60 65
P 30 35 40 45 50 55 60 65 70 75
P 40 45 50 55 60 65 70 75 80 85
P 50 55 60 65 70 75 80 85 90 95
E 60 70 80 90 100 110 120 130
E 80 90 100 110 120 130 140 150
E 100 110 120 130 140 150 160 170
E 120 130 140 150 160 170 180 190

// ==== filelist.f ====
source/ConvPkg.sv
source/LineBuffer.sv
source/WindowGen.sv
source/KernelRegs.sv
source/MacTree.sv
source/ConvEngine.sv
tb/ConvEngineTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ConvEngineTb
RTL_TOP   ?= ConvEngine
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall
PASS_TEXT ?= TB PASSED
RTL_SRCS  ?= $(shell grep '^source/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
